//--- rtl/periph_pkg.sv
// Shared definitions for the peripheral corner of the SoC
// Wishbone request and response structs, GPIO vector type
// Address map, register offsets, reset hold length

package periph_pkg;

  // Bus geometry
  localparam int WB_ADR_W = 12;
  localparam int WB_DAT_W = 32;
  localparam int WB_SEL_W = 4;

  // Address map, each region is aligned to its size
  localparam logic [WB_ADR_W-1:0] PRCI_BASE   = 12'h000;
  localparam logic [WB_ADR_W-1:0] GPIO_BASE   = 12'h100;
  localparam logic [WB_ADR_W-1:0] REGION_SIZE = 12'h100;
  // Offset bits inside one region
  localparam logic [WB_ADR_W-1:0] REGION_MASK = REGION_SIZE - 12'h001;

  // PRCI registers
  localparam logic [WB_ADR_W-1:0] PRCI_STATUS = 12'h000;
  localparam logic [WB_ADR_W-1:0] PRCI_CTRL   = 12'h004;
  localparam logic [WB_ADR_W-1:0] PRCI_RSTCNT = 12'h008;

  // Status bit positions
  localparam int STAT_SYS_REL = 0;
  localparam int STAT_PLL_LOCK = 1;
  localparam int STAT_CALIB = 2;

  // GPIO registers
  localparam logic [WB_ADR_W-1:0] GPIO_DIR = 12'h000;
  localparam logic [WB_ADR_W-1:0] GPIO_OUT = 12'h004;
  localparam logic [WB_ADR_W-1:0] GPIO_IN  = 12'h008;

  localparam int GPIO_W = 12;

  // Cycles of good conditions before a reset is released
  localparam int RST_HOLD_CYCLES = 16;
  localparam int HOLD_CNT_W = $clog2(RST_HOLD_CYCLES);
  localparam logic [HOLD_CNT_W-1:0] RST_HOLD_LAST = HOLD_CNT_W'(RST_HOLD_CYCLES - 1);

  // Master to slave
  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_ADR_W-1:0] adr;
    logic [WB_SEL_W-1:0] sel;
    logic [WB_DAT_W-1:0] dat;
  } wb_req_t;

  // Slave to master
  typedef struct packed {
    logic                ack;
    logic                err;
    logic [WB_DAT_W-1:0] dat;
  } wb_rsp_t;

  typedef logic [GPIO_W-1:0] gpio_vec_t;

endpackage

//--- rtl/prci_ctrl.sv
// PLL and reset control block
// Releases system and debug resets after a hold count of good inputs
// Registers: status, soft reset request, count of system reset releases

module prci_ctrl (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  logic                i_pll_locked,
  input  logic                i_ddr_calib_done,
  input  periph_pkg::wb_req_t i_wb_req,
  output periph_pkg::wb_rsp_t o_wb_rsp,
  output logic                o_sys_rst_n,
  output logic                o_dbg_rst_n
);

  // Index 0 is the system reset, index 1 the debug reset
  logic [1:0]                          good;
  logic [1:0]                          rel_q;
  logic [1:0]                          rel_set;
  logic [periph_pkg::HOLD_CNT_W-1:0]   hold_cnt [2];
  logic                                soft_req;
  logic [periph_pkg::WB_DAT_W-1:0]     rst_count;
  logic                                req_valid;
  logic                                ctrl_wr;
  logic                                ack;
  logic [periph_pkg::WB_DAT_W-1:0]     rd_dat;
  logic [periph_pkg::WB_DAT_W-1:0]     rsp_dat;

  // Board reset enters through the synchronous reset itself
  assign good[0] = i_pll_locked && i_ddr_calib_done && !soft_req;
  assign good[1] = i_pll_locked;

  // Release fires on the last hold cycle
  assign rel_set[0] = good[0] && !rel_q[0] && (hold_cnt[0] == periph_pkg::RST_HOLD_LAST);
  assign rel_set[1] = good[1] && !rel_q[1] && (hold_cnt[1] == periph_pkg::RST_HOLD_LAST);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      for (int i = 0; i < 2; i++) begin
        hold_cnt[i] <= '0;
      end
      rel_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (!good[i]) begin
          // Any bad condition restarts the hold
          hold_cnt[i] <= '0;
          rel_q[i] <= 1'b0;
        end else if (rel_set[i]) begin
          rel_q[i] <= 1'b1;
        end else if (!rel_q[i]) begin
          hold_cnt[i] <= hold_cnt[i] + 1'b1;
        end
      end
    end
  end

  assign o_sys_rst_n = rel_q[0];
  assign o_dbg_rst_n = rel_q[1];

  // New request only on the first strobe cycle
  assign req_valid = i_wb_req.cyc && i_wb_req.stb && !ack;
  assign ctrl_wr = req_valid && i_wb_req.we && (i_wb_req.adr == periph_pkg::PRCI_CTRL) &&
                   i_wb_req.sel[0] && i_wb_req.dat[0];

  // Soft reset request lives until the system reset is seen low
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      soft_req <= 1'b0;
    end else if (ctrl_wr) begin
      soft_req <= 1'b1;
    end else if (!rel_q[0]) begin
      soft_req <= 1'b0;
    end
  end

  // Release count, kept across soft resets
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      rst_count <= '0;
    end else if (rel_set[0]) begin
      rst_count <= rst_count + 1'b1;
    end
  end

  always_comb begin
    rd_dat = '0;
    case (i_wb_req.adr)
      periph_pkg::PRCI_STATUS: begin
        rd_dat[periph_pkg::STAT_SYS_REL] = rel_q[0];
        rd_dat[periph_pkg::STAT_PLL_LOCK] = i_pll_locked;
        rd_dat[periph_pkg::STAT_CALIB] = i_ddr_calib_done;
      end
      periph_pkg::PRCI_RSTCNT: rd_dat = rst_count;
      default: rd_dat = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= req_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (req_valid) begin
      rsp_dat <= rd_dat;
    end
  end

  assign o_wb_rsp = '{ack: ack, err: 1'b0, dat: rsp_dat};

  // Every ack answers a strobe seen on the edge before
  a_ack_after_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(o_wb_rsp.ack) |-> $past(i_wb_req.cyc && i_wb_req.stb));

endmodule

//--- rtl/gpio_ctrl.sv
// GPIO controller
// Direction and output registers with byte-select writes
// Two-flop synchronizer on the input pins, read back with output override

module gpio_ctrl (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  periph_pkg::wb_req_t   i_wb_req,
  output periph_pkg::wb_rsp_t   o_wb_rsp,
  input  periph_pkg::gpio_vec_t i_gpio,
  output periph_pkg::gpio_vec_t o_gpio,
  output periph_pkg::gpio_vec_t o_gpio_dir
);

  periph_pkg::gpio_vec_t           dir_q;
  periph_pkg::gpio_vec_t           out_q;
  periph_pkg::gpio_vec_t           sync1;
  periph_pkg::gpio_vec_t           sync2;
  periph_pkg::gpio_vec_t           pin_view;
  logic                            req_valid;
  logic                            wr_en;
  logic                            ack;
  logic [periph_pkg::WB_DAT_W-1:0] rd_dat;
  logic [periph_pkg::WB_DAT_W-1:0] rsp_dat;

  // Update only the bits whose byte lane is selected
  function automatic periph_pkg::gpio_vec_t merge_sel(
    input periph_pkg::gpio_vec_t           old_val,
    input logic [periph_pkg::WB_DAT_W-1:0] wdat,
    input logic [periph_pkg::WB_SEL_W-1:0] sel
  );
    periph_pkg::gpio_vec_t res;
    res = old_val;
    for (int i = 0; i < periph_pkg::GPIO_W; i++) begin
      if (sel[i/8]) begin
        res[i] = wdat[i];
      end
    end
    return res;
  endfunction

  assign req_valid = i_wb_req.cyc && i_wb_req.stb && !ack;
  assign wr_en = req_valid && i_wb_req.we;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      dir_q <= '0;
      out_q <= '0;
    end else if (wr_en) begin
      case (i_wb_req.adr)
        periph_pkg::GPIO_DIR: dir_q <= merge_sel(dir_q, i_wb_req.dat, i_wb_req.sel);
        periph_pkg::GPIO_OUT: out_q <= merge_sel(out_q, i_wb_req.dat, i_wb_req.sel);
        default: ;
      endcase
    end
  end

  // Pin synchronizer
  always_ff @(posedge i_clk) begin
    sync1 <= i_gpio;
    sync2 <= sync1;
  end

  // Output pins read their own drive value
  assign pin_view = (out_q & dir_q) | (sync2 & ~dir_q);

  always_comb begin
    rd_dat = '0;
    case (i_wb_req.adr)
      periph_pkg::GPIO_DIR: rd_dat[periph_pkg::GPIO_W-1:0] = dir_q;
      periph_pkg::GPIO_OUT: rd_dat[periph_pkg::GPIO_W-1:0] = out_q;
      periph_pkg::GPIO_IN:  rd_dat[periph_pkg::GPIO_W-1:0] = pin_view;
      default: rd_dat = '0;
    endcase
  end

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= req_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (req_valid) begin
      rsp_dat <= rd_dat;
    end
  end

  assign o_wb_rsp = '{ack: ack, err: 1'b0, dat: rsp_dat};
  assign o_gpio = out_q;
  assign o_gpio_dir = dir_q;

  // One response kind at a time, and ack is a single-cycle pulse
  a_ack_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_wb_rsp.ack |-> !o_wb_rsp.err ##1 !o_wb_rsp.ack);

endmodule

//--- rtl/wb_periph_decode.sv
// Wishbone address decoder for the peripheral regions
// Gates the strobe to one slave and passes the region offset
// Answers unmapped addresses with a one-cycle error

module wb_periph_decode (
  input  logic                i_clk,
  input  logic                i_rst_n,
  input  periph_pkg::wb_req_t i_host_req,
  output periph_pkg::wb_rsp_t o_host_rsp,
  output periph_pkg::wb_req_t o_prci_req,
  output periph_pkg::wb_req_t o_gpio_req,
  input  periph_pkg::wb_rsp_t i_prci_rsp,
  input  periph_pkg::wb_rsp_t i_gpio_rsp
);

  typedef enum logic [1:0] {
    REG_PRCI,
    REG_GPIO,
    REG_NONE
  } region_e;

  region_e                         region;
  region_e                         region_q;
  logic [periph_pkg::WB_ADR_W-1:0] region_base;
  logic                            req_valid;
  logic                            err_q;

  assign region_base = i_host_req.adr & ~periph_pkg::REGION_MASK;
  assign req_valid = i_host_req.cyc && i_host_req.stb;

  always_comb begin
    if (region_base == periph_pkg::PRCI_BASE) begin
      region = REG_PRCI;
    end else if (region_base == periph_pkg::GPIO_BASE) begin
      region = REG_GPIO;
    end else begin
      region = REG_NONE;
    end
  end

  // Slaves see the offset inside their own region
  always_comb begin
    o_prci_req = i_host_req;
    o_prci_req.adr = i_host_req.adr & periph_pkg::REGION_MASK;
    o_prci_req.cyc = i_host_req.cyc && (region == REG_PRCI);
    o_prci_req.stb = i_host_req.stb && (region == REG_PRCI);
    o_gpio_req = i_host_req;
    o_gpio_req.adr = i_host_req.adr & periph_pkg::REGION_MASK;
    o_gpio_req.cyc = i_host_req.cyc && (region == REG_GPIO);
    o_gpio_req.stb = i_host_req.stb && (region == REG_GPIO);
  end

  // Region of the request in flight picks the response source
  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      region_q <= REG_NONE;
      err_q <= 1'b0;
    end else begin
      if (req_valid) begin
        region_q <= region;
      end
      err_q <= req_valid && (region == REG_NONE) && !err_q;
    end
  end

  always_comb begin
    case (region_q)
      REG_PRCI: o_host_rsp = i_prci_rsp;
      REG_GPIO: o_host_rsp = i_gpio_rsp;
      default:  o_host_rsp = '{ack: 1'b0, err: err_q, dat: '0};
    endcase
  end

  a_one_slave: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !(o_prci_req.cyc && o_prci_req.stb && o_gpio_req.cyc && o_gpio_req.stb));

endmodule

//--- rtl/soc_periph_top.sv
// Peripheral and reset corner of the SoC
// PRCI and decoder on the board reset, GPIO on the system reset

module soc_periph_top (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic                  i_pll_locked,
  input  logic                  i_ddr_calib_done,
  input  periph_pkg::wb_req_t   i_wb_req,
  output periph_pkg::wb_rsp_t   o_wb_rsp,
  input  periph_pkg::gpio_vec_t i_gpio,
  output periph_pkg::gpio_vec_t o_gpio,
  output periph_pkg::gpio_vec_t o_gpio_dir,
  output logic                  o_sys_rst_n,
  output logic                  o_dbg_rst_n
);

  periph_pkg::wb_req_t w_prci_req;
  periph_pkg::wb_req_t w_gpio_req;
  periph_pkg::wb_rsp_t w_prci_rsp;
  periph_pkg::wb_rsp_t w_gpio_rsp;

  prci_ctrl prci0 (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_pll_locked     (i_pll_locked),
    .i_ddr_calib_done (i_ddr_calib_done),
    .i_wb_req         (w_prci_req),
    .o_wb_rsp         (w_prci_rsp),
    .o_sys_rst_n      (o_sys_rst_n),
    .o_dbg_rst_n      (o_dbg_rst_n)
  );

  wb_periph_decode dec0 (
    .i_clk      (i_clk),
    .i_rst_n    (i_rst_n),
    .i_host_req (i_wb_req),
    .o_host_rsp (o_wb_rsp),
    .o_prci_req (w_prci_req),
    .o_gpio_req (w_gpio_req),
    .i_prci_rsp (w_prci_rsp),
    .i_gpio_rsp (w_gpio_rsp)
  );

  // GPIO stays silent while the system reset is held
  gpio_ctrl gpio0 (
    .i_clk      (i_clk),
    .i_rst_n    (o_sys_rst_n),
    .i_wb_req   (w_gpio_req),
    .o_wb_rsp   (w_gpio_rsp),
    .i_gpio     (i_gpio),
    .o_gpio     (o_gpio),
    .o_gpio_dir (o_gpio_dir)
  );

endmodule

//--- sim/tb_soc_periph.sv
// Testbench for the peripheral and reset corner
// Operation table applied in a loop, LFSR data and pin values
// Compare tasks for bus responses, GPIO vectors and reset outputs

module tb_soc_periph;

  localparam int CLK_PERIOD = 40;
  localparam int RST_CYCLES = 8;
  localparam int OP_CYCLES = 64;
  localparam int LOCK_SETTLE = 2;
  localparam int WAIT_LIMIT = 3 * periph_pkg::RST_HOLD_CYCLES;
  localparam logic [15:0] LFSR_SEED = 16'd14409;
  localparam logic [11:0] A_STATUS = periph_pkg::PRCI_BASE + periph_pkg::PRCI_STATUS;
  localparam logic [11:0] A_CTRL = periph_pkg::PRCI_BASE + periph_pkg::PRCI_CTRL;
  localparam logic [11:0] A_RSTCNT = periph_pkg::PRCI_BASE + periph_pkg::PRCI_RSTCNT;
  localparam logic [11:0] A_DIR = periph_pkg::GPIO_BASE + periph_pkg::GPIO_DIR;
  localparam logic [11:0] A_OUT = periph_pkg::GPIO_BASE + periph_pkg::GPIO_OUT;
  localparam logic [11:0] A_IN = periph_pkg::GPIO_BASE + periph_pkg::GPIO_IN;
  localparam logic [11:0] A_UNMAPPED = 12'h300;

  typedef enum logic [1:0] {OP_WR, OP_RD, OP_LOCK, OP_WAIT} op_kind_e;

  // Lock entries: wdat is {calib, pll}, exp_dat is {dbg, sys}
  // Wait entries: exp_dat is the release cycle count, 0 when not checked
  typedef struct packed {
    op_kind_e                        kind;
    logic [periph_pkg::WB_ADR_W-1:0] adr;
    logic [periph_pkg::WB_DAT_W-1:0] wdat;
    logic [periph_pkg::WB_DAT_W-1:0] exp_dat;
    logic                            exp_err;
    periph_pkg::gpio_vec_t           exp_gpio;
  } op_t;

  logic                  clk;
  logic                  rst_n;
  logic                  pll_locked;
  logic                  calib_done;
  periph_pkg::wb_req_t   wb_req;
  periph_pkg::wb_rsp_t   wb_rsp;
  periph_pkg::gpio_vec_t pins;
  periph_pkg::gpio_vec_t gpio_out;
  periph_pkg::gpio_vec_t gpio_dir;
  logic                  sys_rst_n;
  logic                  dbg_rst_n;
  op_t                   ops[$];
  logic [15:0]           lfsr_state;
  int                    errors;
  bit                    table_ready;

  soc_periph_top uut (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_pll_locked     (pll_locked),
    .i_ddr_calib_done (calib_done),
    .i_wb_req         (wb_req),
    .o_wb_rsp         (wb_rsp),
    .i_gpio           (pins),
    .o_gpio           (gpio_out),
    .o_gpio_dir       (gpio_dir),
    .o_sys_rst_n      (sys_rst_n),
    .o_dbg_rst_n      (dbg_rst_n)
  );

  // Fibonacci LFSR, x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic add_op(input op_kind_e kind, input logic [11:0] adr, input logic [31:0] wdat,
                        input logic [31:0] exp_dat, input logic exp_err,
                        input periph_pkg::gpio_vec_t exp_gpio);
    op_t op;
    op.kind = kind;
    op.adr = adr;
    op.wdat = wdat;
    op.exp_dat = exp_dat;
    op.exp_err = exp_err;
    op.exp_gpio = exp_gpio;
    ops.push_back(op);
  endtask

  task automatic check_rsp(input periph_pkg::wb_rsp_t got, input periph_pkg::wb_rsp_t exp,
                           input bit use_dat);
    if (got.ack !== exp.ack || got.err !== exp.err || (use_dat && got.dat !== exp.dat)) begin
      $display("[FAIL] %0t: ack=%0b err=%0b dat=0x%08h, expected ack=%0b err=%0b dat=0x%08h",
               $time, got.ack, got.err, got.dat, exp.ack, exp.err, exp.dat);
      errors++;
    end
  endtask

  task automatic check_gpio(input string what, input periph_pkg::gpio_vec_t got,
                            input periph_pkg::gpio_vec_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t: %s is 0x%03h, expected 0x%03h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_rst(input logic got_sys, input logic got_dbg,
                           input logic exp_sys, input logic exp_dbg);
    if (got_sys !== exp_sys || got_dbg !== exp_dbg) begin
      $display("[FAIL] %0t: resets sys=%0b dbg=%0b, expected sys=%0b dbg=%0b",
               $time, got_sys, got_dbg, exp_sys, exp_dbg);
      errors++;
    end
  endtask

  // Classic cycle, request held until ack or err is seen
  task automatic bus_cycle(input logic we, input logic [11:0] adr, input logic [31:0] wdat,
                           output periph_pkg::wb_rsp_t rsp, output int cycles);
    cycles = 0;
    @(negedge clk);
    wb_req.cyc = 1'b1;
    wb_req.stb = 1'b1;
    wb_req.we = we;
    wb_req.adr = adr;
    wb_req.sel = '1;
    wb_req.dat = wdat;
    do begin
      @(negedge clk);
      cycles++;
    end while (!wb_rsp.ack && !wb_rsp.err && cycles < OP_CYCLES);
    rsp = wb_rsp;
    wb_req = '0;
  endtask

  task automatic apply_op(input op_t op);
    periph_pkg::wb_rsp_t rsp;
    periph_pkg::wb_rsp_t exp;
    int cycles;
    int dbg_cycles;
    logic dbg_was_low;
    case (op.kind)
      OP_WR, OP_RD: begin
        if (op.kind == OP_RD && op.adr == A_IN) begin
          @(negedge clk);
          pins = op.wdat[periph_pkg::GPIO_W-1:0];
          repeat (2) @(negedge clk);
        end
        bus_cycle(op.kind == OP_WR, op.adr, op.wdat, rsp, cycles);
        if (cycles >= OP_CYCLES) begin
          $display("Bus access to 0x%03h got neither ack nor err", op.adr);
          errors++;
        end else begin
          if (cycles != 1) begin
            $display("[FAIL] %0t: response after %0d cycles, expected 1", $time, cycles);
            errors++;
          end
          exp.ack = !op.exp_err;
          exp.err = op.exp_err;
          exp.dat = op.exp_dat;
          check_rsp(rsp, exp, op.kind == OP_RD || op.exp_err);
          if (op.kind == OP_WR && op.adr == A_DIR) begin
            check_gpio("o_gpio_dir", gpio_dir, op.exp_gpio);
          end
          if (op.kind == OP_WR && op.adr == A_OUT) begin
            check_gpio("o_gpio", gpio_out, op.exp_gpio);
          end
        end
      end
      OP_LOCK: begin
        @(negedge clk);
        pll_locked = op.wdat[0];
        calib_done = op.wdat[1];
        repeat (LOCK_SETTLE) @(negedge clk);
        check_rst(sys_rst_n, dbg_rst_n, op.exp_dat[0], op.exp_dat[1]);
      end
      default: begin
        cycles = 0;
        dbg_cycles = 0;
        dbg_was_low = !dbg_rst_n;
        while (!sys_rst_n && cycles < WAIT_LIMIT) begin
          @(negedge clk);
          cycles++;
          if (dbg_was_low && dbg_rst_n && dbg_cycles == 0) begin
            dbg_cycles = cycles;
          end
        end
        if (!sys_rst_n) begin
          $display("System reset was not released within %0d cycles", WAIT_LIMIT);
          errors++;
        end else begin
          if (op.exp_dat != 0 && cycles != op.exp_dat) begin
            $display("[FAIL] %0t: release after %0d cycles, expected %0d",
                     $time, cycles, op.exp_dat);
            errors++;
          end
          // Debug reset runs the same hold count when it starts low
          if (op.exp_dat != 0 && dbg_was_low && dbg_cycles != op.exp_dat) begin
            $display("[FAIL] %0t: debug release after %0d cycles, expected %0d",
                     $time, dbg_cycles, op.exp_dat);
            errors++;
          end
          check_rst(sys_rst_n, dbg_rst_n, 1'b1, 1'b1);
          check_gpio("o_gpio", gpio_out, op.exp_gpio);
          check_gpio("o_gpio_dir", gpio_dir, op.exp_gpio);
        end
      end
    endcase
  endtask

  task automatic build_table();
    periph_pkg::gpio_vec_t dir_m;
    periph_pkg::gpio_vec_t out_m;
    periph_pkg::gpio_vec_t pin_val;
    periph_pkg::gpio_vec_t pin_exp;
    logic [31:0] r;
    // Release from the board reset
    add_op(OP_WAIT, 12'h000, 32'd0, 32'(periph_pkg::RST_HOLD_CYCLES), 1'b0, '0);
    add_op(OP_RD, A_STATUS, 32'd0, 32'd7, 1'b0, '0);
    add_op(OP_RD, A_RSTCNT, 32'd0, 32'd1, 1'b0, '0);
    draw_bits(32, r);
    dir_m = r[periph_pkg::GPIO_W-1:0];
    add_op(OP_WR, A_DIR, r, 32'd0, 1'b0, dir_m);
    draw_bits(32, r);
    out_m = r[periph_pkg::GPIO_W-1:0];
    add_op(OP_WR, A_OUT, r, 32'd0, 1'b0, out_m);
    add_op(OP_RD, A_DIR, 32'd0, 32'(dir_m), 1'b0, '0);
    add_op(OP_RD, A_OUT, 32'd0, 32'(out_m), 1'b0, '0);
    // Output pins read their drive value, input pins the board value
    for (int i = 0; i < 3; i++) begin
      draw_bits(periph_pkg::GPIO_W, r);
      pin_val = r[periph_pkg::GPIO_W-1:0];
      for (int b = 0; b < periph_pkg::GPIO_W; b++) begin
        pin_exp[b] = dir_m[b] ? out_m[b] : pin_val[b];
      end
      add_op(OP_RD, A_IN, r, 32'(pin_exp), 1'b0, '0);
      draw_bits(32, r);
      dir_m = r[periph_pkg::GPIO_W-1:0];
      add_op(OP_WR, A_DIR, r, 32'd0, 1'b0, dir_m);
    end
    add_op(OP_RD, A_UNMAPPED, 32'd0, 32'd0, 1'b1, '0);
    draw_bits(32, r);
    add_op(OP_WR, A_UNMAPPED, r, 32'd0, 1'b1, '0);
    add_op(OP_WR, periph_pkg::GPIO_BASE + 12'h00C, r, 32'd0, 1'b0, '0);
    add_op(OP_RD, periph_pkg::GPIO_BASE + 12'h00C, 32'd0, 32'd0, 1'b0, '0);
    add_op(OP_RD, periph_pkg::PRCI_BASE + 12'h00C, 32'd0, 32'd0, 1'b0, '0);
    add_op(OP_RD, A_DIR, 32'd0, 32'(dir_m), 1'b0, '0);
    add_op(OP_RD, A_OUT, 32'd0, 32'(out_m), 1'b0, '0);
    // Soft reset clears GPIO, debug reset stays released
    add_op(OP_WR, A_CTRL, 32'd1, 32'd0, 1'b0, '0);
    add_op(OP_LOCK, 12'h000, 32'b11, 32'b10, 1'b0, '0);
    add_op(OP_WAIT, 12'h000, 32'd0, 32'd0, 1'b0, '0);
    add_op(OP_RD, A_DIR, 32'd0, 32'd0, 1'b0, '0);
    add_op(OP_RD, A_OUT, 32'd0, 32'd0, 1'b0, '0);
    add_op(OP_RD, A_RSTCNT, 32'd0, 32'd2, 1'b0, '0);
    // Loss of PLL lock, then loss of calibration only
    add_op(OP_LOCK, 12'h000, 32'b10, 32'b00, 1'b0, '0);
    add_op(OP_LOCK, 12'h000, 32'b11, 32'b00, 1'b0, '0);
    add_op(OP_WAIT, 12'h000, 32'd0, 32'(periph_pkg::RST_HOLD_CYCLES - LOCK_SETTLE), 1'b0, '0);
    add_op(OP_RD, A_STATUS, 32'd0, 32'd7, 1'b0, '0);
    add_op(OP_LOCK, 12'h000, 32'b01, 32'b10, 1'b0, '0);
    add_op(OP_RD, A_STATUS, 32'd0, 32'd2, 1'b0, '0);
    add_op(OP_LOCK, 12'h000, 32'b11, 32'b10, 1'b0, '0);
    add_op(OP_WAIT, 12'h000, 32'd0, 32'(periph_pkg::RST_HOLD_CYCLES - LOCK_SETTLE), 1'b0, '0);
    add_op(OP_RD, A_RSTCNT, 32'd0, 32'd4, 1'b0, '0);
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    int fails_before;
    rst_n = 1'b0;
    pll_locked = 1'b1;
    calib_done = 1'b1;
    wb_req = '0;
    pins = '0;
    errors = 0;
    lfsr_state = LFSR_SEED;
    build_table();
    table_ready = 1'b1;
    repeat (RST_CYCLES) @(negedge clk);
    check_rst(sys_rst_n, dbg_rst_n, 1'b0, 1'b0);
    check_gpio("o_gpio", gpio_out, '0);
    check_gpio("o_gpio_dir", gpio_dir, '0);
    check_rsp(wb_rsp, '0, 1'b0);
    $display("reset outputs: %s", (errors == 0) ? "ok" : "wrong");
    rst_n = 1'b1;
    for (int i = 0; i < ops.size(); i++) begin
      fails_before = errors;
      apply_op(ops[i]);
      $display("entry %0d kind %0d adr 0x%03h: %s", i, ops[i].kind, ops[i].adr,
               (errors == fails_before) ? "ok" : "wrong");
    end
    $display("%0d entries run, %0d checks wrong", ops.size(), errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Each entry gets a fixed budget of cycles
  initial begin
    wait (table_ready);
    #(ops.size() * OP_CYCLES * CLK_PERIOD);
    $display("Watchdog: run timed out before the operation table finished");
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- all.f
rtl/periph_pkg.sv
rtl/prci_ctrl.sv
rtl/gpio_ctrl.sv
rtl/wb_periph_decode.sv
rtl/soc_periph_top.sv
sim/tb_soc_periph.sv

//--- run.sh
#!/bin/sh
# Compile the peripheral testbench with Verilator, run it, search the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_soc_periph -f all.f -o tb_soc_periph

./obj_dir/tb_soc_periph 2>&1 | tee sim.log

if grep -qx "Simulation passed" sim.log; then
  echo "run.sh: pass message found in sim.log"
else
  echo "run.sh: pass message missing from sim.log"
  exit 1
fi
